/* flist.f */
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_array.sv
hw/dcache_link.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache.sv

/* run.sh */
#!/bin/sh
# compile the cache with its testbench, run it, and decide on the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f flist.f \
    -o sim_dcache \
    && ./obj_dir/sim_dcache | tee /dev/stderr | grep -q "Everything OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* testbench/tb_dcache.sv */
// data cache testbench with reference model, compare task, timeout and report
module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int MEM_WORDS = 1024;
    // tests need roughly 3000 cycles even with every access missing dirty
    localparam int TIMEOUT_CYCLES = 20000;

    logic  CLK = 1'b0;
    logic  nRST;
    logic  dmem_ren, dmem_wen, datomic, halt;
    word_t dmem_addr, dmem_store, dmem_load;
    logic  dhit, flushed;
    logic  mem_ren, mem_wen, mem_wait;
    word_t mem_addr, mem_store, mem_load;

    // expected memory contents and link state
    word_t ref_mem [MEM_WORDS];
    logic  touched [MEM_WORDS];
    logic  ref_link_valid;
    word_t ref_link_addr;

    logic [31:0] rng_state = 32'hd3d2956e;
    int cycles = 0;
    int checks = 0;
    int errors = 0;

    // expectation for the request in flight
    logic  exp_valid = 1'b0;
    word_t exp_value = '0;
    string exp_what = "";

    dcache_top UUT (
        .CLK, .nRST,
        .dmem_ren, .dmem_wen, .datomic, .dmem_addr, .dmem_store, .halt,
        .dhit, .dmem_load, .flushed,
        .mem_ren, .mem_wen, .mem_addr, .mem_store, .mem_load, .mem_wait
    );

    tb_mem_model mem (
        .CLK, .nRST, .mem_ren, .mem_wen, .mem_addr, .mem_store, .mem_load, .mem_wait
    );

    always #5 CLK = ~CLK;

    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // word-aligned address inside the model's 4 KB
    function automatic word_t random_addr();
        word_t r;
        r = next_random();
        return {20'b0, r[11:2], 2'b00};
    endfunction

    function automatic int unsigned word_index(input word_t addr);
        return {22'b0, addr[11:2]};
    endfunction

    function automatic word_t initial_word(input int unsigned w);
        return word_t'(w) * 32'h9e3779b9 + 32'h2545f491;
    endfunction

    // expected load value or sc result, updates the reference state
    function automatic word_t expected_result(input logic is_load, input logic atomic,
                                              input word_t addr, input word_t data);
        int unsigned w;
        logic        linked;
        word_t       result;
        w      = word_index(addr);
        linked = ref_link_valid && (ref_link_addr == addr);
        result = '0;
        if (is_load) begin
            result = ref_mem[w];
            if (atomic) begin
                ref_link_valid = 1'b1;
                ref_link_addr  = addr;
            end
        end else if (!atomic || linked) begin
            ref_mem[w] = data;
            touched[w] = 1'b1;
            // any store to the linked word breaks the link
            if (linked) ref_link_valid = 1'b0;
            result = word_t'(atomic);
        end
        return result;
    endfunction

    task automatic check_value(input word_t got, input word_t expected, input string what);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // one request, held until dhit, entered and left 1 ns after a rising edge
    task automatic access(input logic is_load, input logic atomic, input word_t addr,
                          input word_t data, input logic check, input string what);
        exp_value  = expected_result(is_load, atomic, addr, data);
        exp_valid  = check;
        exp_what   = what;
        dmem_ren   = is_load;
        dmem_wen   = !is_load;
        datomic    = atomic;
        dmem_addr  = addr;
        dmem_store = data;
        do @(negedge CLK); while (!dhit);
        @(posedge CLK);
        #1;
        dmem_ren  = 1'b0;
        dmem_wen  = 1'b0;
        datomic   = 1'b0;
        exp_valid = 1'b0;
    endtask

    task automatic load_word(input word_t addr, input string what);
        access(1'b1, 1'b0, addr, '0, 1'b1, what);
    endtask

    task automatic store_word(input word_t addr, input word_t data);
        access(1'b0, 1'b0, addr, data, 1'b0, "store");
    endtask

    task automatic load_linked(input word_t addr);
        access(1'b1, 1'b1, addr, '0, 1'b1, "load-linked value");
    endtask

    task automatic store_cond(input word_t addr, input word_t data, input string what);
        access(1'b0, 1'b1, addr, data, 1'b1, what);
    endtask

    task automatic report_test(input string name, input int start_errors);
        $display("%s finished with %0d errors", name, errors - start_errors);
    endtask

    // dmem_load compare while dhit is stable mid-cycle
    always @(negedge CLK) begin
        if (nRST && dhit && exp_valid) begin
            check_value(dmem_load, exp_value, exp_what);
        end
    end

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        word_t       addrs[$];
        word_t       a, r;
        word_t       same_set [3];
        int unsigned w;
        int          start_errors;

        nRST       = 1'b0;
        dmem_ren   = 1'b0;
        dmem_wen   = 1'b0;
        datomic    = 1'b0;
        halt       = 1'b0;
        dmem_addr  = '0;
        dmem_store = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = initial_word(i);
            touched[i] = 1'b0;
        end
        ref_link_valid = 1'b0;
        ref_link_addr  = '0;
        repeat (10) @(posedge CLK);
        #1;
        nRST = 1'b1;

        // misses then hits on the initial contents
        start_errors = errors;
        for (int i = 0; i < 16; i++) begin
            a = random_addr();
            load_word(a, "load after reset");
            load_word(a, "repeated load");
        end
        report_test("loads after reset", start_errors);

        start_errors = errors;
        for (int i = 0; i < 32; i++) begin
            a = random_addr();
            addrs.push_back(a);
            store_word(a, next_random());
        end
        foreach (addrs[i]) load_word(addrs[i], "load after store");
        report_test("stores and reloads", start_errors);

        // three tags in one set, every block gets evicted dirty once
        start_errors = errors;
        r = next_random();
        for (int i = 0; i < 3; i++) begin
            same_set[i] = {20'b0, r[5:0] + 6'(i), r[8:6], 1'b0, 2'b00};
            store_word(same_set[i], next_random());
        end
        for (int i = 0; i < 3; i++) load_word(same_set[i], "reload after eviction");
        for (int i = 0; i < 3; i++) begin
            w = word_index(same_set[i]);
            check_value(mem.words[w], ref_mem[w], "evicted word 0 in memory");
            check_value(mem.words[w + 1], ref_mem[w + 1], "evicted word 1 in memory");
        end
        report_test("dirty evictions", start_errors);

        start_errors = errors;
        a = random_addr();
        load_linked(a);
        store_cond(a, next_random(), "sc after ll");
        load_word(a, "load after sc");
        load_linked(a);
        store_word(a, next_random());
        store_cond(a, next_random(), "sc after plain store");
        load_word(a, "load after failed sc");
        report_test("load-linked and store-conditional", start_errors);

        start_errors = errors;
        halt = 1'b1;
        do @(negedge CLK); while (!flushed);
        repeat (5) begin
            @(negedge CLK);
            check_value(word_t'(flushed), 32'd1, "flushed held high");
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (touched[i]) check_value(mem.words[i], ref_mem[i], "memory after flush");
        end
        report_test("halt flush", start_errors);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* testbench/tb_mem_model.sv */
// word-addressed memory model with a fixed-latency request/wait handshake
module tb_mem_model (
    input  logic              CLK,
    input  logic              nRST,
    input  logic              mem_ren,
    input  logic              mem_wen,
    input  dcache_pkg::word_t mem_addr,
    input  dcache_pkg::word_t mem_store,
    output dcache_pkg::word_t mem_load,
    output logic              mem_wait
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int WORDS = 1024;
    // wait stays high this many cycles before each transfer
    localparam logic [1:0] LATENCY = 2'd3;

    // read by the testbench to check write-backs
    word_t words [WORDS];

    logic [1:0] wait_cnt;
    logic [9:0] word_sel;
    logic       active;

    assign word_sel = mem_addr[11:2];
    assign active   = mem_ren || mem_wen;
    assign mem_wait = !(active && (wait_cnt == LATENCY));
    assign mem_load = words[word_sel];

    // fill pattern, a different value for every word address
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            words[i] = word_t'(i) * 32'h9e3779b9 + 32'h2545f491;
        end
    end

    // restart the count after every transfer, the next request may follow at once
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt <= '0;
        end else if (!active || !mem_wait) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 2'd1;
        end
    end

    always @(posedge CLK) begin
        if (mem_wen && !mem_wait) begin
            words[word_sel] <= mem_store;
        end
    end

endmodule

/* hw/dcache_top.sv */
// dcache_top: data cache top level, array, controller and link register
`include "dcache_cfg.svh"

module dcache_top (
    input  logic              CLK,
    input  logic              nRST,
    // datapath side
    input  logic              dmem_ren,
    input  logic              dmem_wen,
    input  logic              datomic,
    input  dcache_pkg::word_t dmem_addr,
    input  dcache_pkg::word_t dmem_store,
    input  logic              halt,
    output logic              dhit,
    output dcache_pkg::word_t dmem_load,
    output logic              flushed,
    // memory side
    output logic              mem_ren,
    output logic              mem_wen,
    output dcache_pkg::word_t mem_addr,
    output dcache_pkg::word_t mem_store,
    input  dcache_pkg::word_t mem_load,
    input  logic              mem_wait
);
    import dcache_pkg::*;

    idx_t  req_idx;
    tag_t  req_tag, victim_tag, wr_tag, flush_tag;
    logic  req_blk, hit, hit_way, victim_way, victim_dirty;
    word_t rd_word0, rd_word1, wr_word0, wr_word1, flush_word0, flush_word1;
    logic  frame_wen, wr_way, wr_valid, wr_dirty, lru_wen, lru_val;
    logic  flush_dirty, flush_clean;
    logic  link_ok, link_set, link_clear;
    logic [`DCACHE_FLUSH_W-1:0] flush_sel;

    dcache_array u_array (
        .CLK, .nRST,
        .req_idx, .req_tag, .req_blk,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .rd_word0, .rd_word1,
        .frame_wen, .wr_way, .wr_valid, .wr_dirty, .wr_tag, .wr_word0, .wr_word1,
        .lru_wen, .lru_val,
        .flush_sel, .flush_dirty, .flush_tag, .flush_word0, .flush_word1, .flush_clean
    );

    dcache_ctrl u_ctrl (
        .CLK, .nRST,
        .dmem_ren, .dmem_wen, .datomic, .halt, .dmem_addr, .dmem_store,
        .dhit, .flushed, .dmem_load,
        .req_idx, .req_tag, .req_blk,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
        .rd_word0, .rd_word1,
        .frame_wen, .wr_way, .wr_valid, .wr_dirty, .wr_tag, .wr_word0, .wr_word1,
        .lru_wen, .lru_val,
        .flush_sel, .flush_dirty, .flush_tag, .flush_word0, .flush_word1, .flush_clean,
        .link_ok, .link_set, .link_clear,
        .mem_ren, .mem_wen, .mem_addr, .mem_store, .mem_load, .mem_wait
    );

    // link compare runs on the full request address
    dcache_link u_link (
        .CLK, .nRST,
        .addr       (dmem_addr),
        .link_set,
        .link_clear,
        .link_ok
    );

endmodule

/* hw/dcache_ctrl.sv */
// dcache_ctrl: hit, miss, write-back, fill and halt flush state machine
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          dmem_ren,
    input  logic                          dmem_wen,
    input  logic                          datomic,
    input  logic                          halt,
    input  dcache_pkg::word_t             dmem_addr,
    input  dcache_pkg::word_t             dmem_store,
    output logic                          dhit,
    output logic                          flushed,
    output dcache_pkg::word_t             dmem_load,
    output dcache_pkg::idx_t              req_idx,
    output dcache_pkg::tag_t              req_tag,
    output logic                          req_blk,
    input  logic                          hit,
    input  logic                          hit_way,
    input  logic                          victim_way,
    input  logic                          victim_dirty,
    input  dcache_pkg::tag_t              victim_tag,
    input  dcache_pkg::word_t             rd_word0,
    input  dcache_pkg::word_t             rd_word1,
    output logic                          frame_wen,
    output logic                          wr_way,
    output logic                          wr_valid,
    output logic                          wr_dirty,
    output dcache_pkg::tag_t              wr_tag,
    output dcache_pkg::word_t             wr_word0,
    output dcache_pkg::word_t             wr_word1,
    output logic                          lru_wen,
    output logic                          lru_val,
    output logic [`DCACHE_FLUSH_W-1:0]    flush_sel,
    input  logic                          flush_dirty,
    input  dcache_pkg::tag_t              flush_tag,
    input  dcache_pkg::word_t             flush_word0,
    input  dcache_pkg::word_t             flush_word1,
    output logic                          flush_clean,
    input  logic                          link_ok,
    output logic                          link_set,
    output logic                          link_clear,
    output logic                          mem_ren,
    output logic                          mem_wen,
    output dcache_pkg::word_t             mem_addr,
    output dcache_pkg::word_t             mem_store,
    input  dcache_pkg::word_t             mem_load,
    input  logic                          mem_wait
);
    import dcache_pkg::*;

    dcache_state_t state, next_state;
    logic [`DCACHE_FLUSH_W-1:0] flush_cnt, next_flush_cnt;
    logic  req, sc, store_ok, serve;
    word_t blk_word0, blk_word1, st_word0, st_word1;
    idx_t  flush_idx;

    // address fields
    assign req_tag = dmem_addr[`DCACHE_WORD_W-1 -: `DCACHE_TAG_W];
    assign req_idx = dmem_addr[`DCACHE_BYTE_W + `DCACHE_BLK_W +: `DCACHE_IDX_W];
    assign req_blk = dmem_addr[`DCACHE_BYTE_W];

    assign flush_sel = flush_cnt;
    assign flush_idx = flush_cnt[`DCACHE_IDX_W-1:0];

    assign req      = dmem_ren || dmem_wen;
    assign sc       = datomic && dmem_wen;
    assign store_ok = !sc || link_ok;

    // back to block order from requested/partner order
    assign blk_word0 = req_blk ? rd_word1 : rd_word0;
    assign blk_word1 = req_blk ? rd_word0 : rd_word1;

    // block with the store word merged in
    assign st_word0 = req_blk ? blk_word0 : dmem_store;
    assign st_word1 = req_blk ? dmem_store : blk_word1;

    // requests answered this cycle
    assign serve = (state == IDLE && !halt && req && hit) || (state == STORE_UPDATE);

    always_comb begin
        next_state     = state;
        next_flush_cnt = flush_cnt;
        dhit           = 1'b0;
        dmem_load      = '0;
        flushed        = 1'b0;
        frame_wen      = 1'b0;
        wr_way         = victim_way;
        wr_valid       = 1'b1;
        wr_dirty       = 1'b0;
        wr_tag         = req_tag;
        wr_word0       = blk_word0;
        wr_word1       = blk_word1;
        lru_wen        = 1'b0;
        lru_val        = !hit_way;
        link_set       = 1'b0;
        link_clear     = 1'b0;
        flush_clean    = 1'b0;

        if (serve) begin
            dhit    = 1'b1;
            lru_wen = 1'b1;
            if (dmem_ren) begin
                dmem_load = rd_word0;
                link_set  = datomic;
            end else if (store_ok) begin
                // a failed sc leaves the frame alone and reads back 0
                frame_wen  = 1'b1;
                wr_way     = hit_way;
                wr_dirty   = 1'b1;
                wr_word0   = st_word0;
                wr_word1   = st_word1;
                link_clear = link_ok;
                dmem_load  = word_t'(sc);
            end
        end

        case (state)
            IDLE: begin
                if (halt) begin
                    next_state = CHECK_DIRTY;
                end else if (req && !hit) begin
                    next_state = victim_dirty ? WRITEBACK1 : LOAD1;
                end
            end
            WRITEBACK1: begin
                if (!mem_wait) next_state = WRITEBACK2;
            end
            WRITEBACK2: begin
                if (!mem_wait) next_state = LOAD1;
            end
            LOAD1: begin
                // frame stays invalid until the second word lands
                if (!mem_wait) begin
                    frame_wen  = 1'b1;
                    wr_valid   = 1'b0;
                    wr_word0   = mem_load;
                    next_state = LOAD2;
                end
            end
            LOAD2: begin
                if (!mem_wait) begin
                    frame_wen  = 1'b1;
                    wr_word1   = mem_load;
                    next_state = dmem_wen ? STORE_UPDATE : IDLE;
                end
            end
            STORE_UPDATE: begin
                next_state = IDLE;
            end
            CHECK_DIRTY: begin
                if (flush_cnt[`DCACHE_FLUSH_W-1]) begin
                    next_state = HALTED;
                end else if (flush_dirty) begin
                    next_state = FLUSH_WB1;
                end else begin
                    next_flush_cnt = flush_cnt + 1'b1;
                end
            end
            FLUSH_WB1: begin
                if (!mem_wait) next_state = FLUSH_WB2;
            end
            FLUSH_WB2: begin
                if (!mem_wait) begin
                    flush_clean    = 1'b1;
                    next_flush_cnt = flush_cnt + 1'b1;
                    next_state     = CHECK_DIRTY;
                end
            end
            HALTED: begin
                flushed = 1'b1;
            end
            default: next_state = IDLE;
        endcase
    end

    // memory port, held steady while mem_wait is high
    always_comb begin
        mem_ren   = 1'b0;
        mem_wen   = 1'b0;
        mem_addr  = '0;
        mem_store = '0;
        case (state)
            WRITEBACK1: begin
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag, req_idx, 1'b0, {`DCACHE_BYTE_W{1'b0}}};
                mem_store = blk_word0;
            end
            WRITEBACK2: begin
                mem_wen   = 1'b1;
                mem_addr  = {victim_tag, req_idx, 1'b1, {`DCACHE_BYTE_W{1'b0}}};
                mem_store = blk_word1;
            end
            LOAD1: begin
                mem_ren  = 1'b1;
                mem_addr = {req_tag, req_idx, 1'b0, {`DCACHE_BYTE_W{1'b0}}};
            end
            LOAD2: begin
                mem_ren  = 1'b1;
                mem_addr = {req_tag, req_idx, 1'b1, {`DCACHE_BYTE_W{1'b0}}};
            end
            FLUSH_WB1: begin
                mem_wen   = 1'b1;
                mem_addr  = {flush_tag, flush_idx, 1'b0, {`DCACHE_BYTE_W{1'b0}}};
                mem_store = flush_word0;
            end
            FLUSH_WB2: begin
                mem_wen   = 1'b1;
                mem_addr  = {flush_tag, flush_idx, 1'b1, {`DCACHE_BYTE_W{1'b0}}};
                mem_store = flush_word1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_cnt <= '0;
        end else begin
            state     <= next_state;
            flush_cnt <= next_flush_cnt;
        end
    end

    a_mem_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_ren && mem_wen))
        else $error("memory read and write requested together");

    a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
        flushed |=> flushed)
        else $error("flushed fell after being set");

endmodule

/* hw/dcache_link.sv */
// dcache_link: link register for ll/sc
module dcache_link (
    input  logic              CLK,
    input  logic              nRST,
    input  dcache_pkg::word_t addr,
    input  logic              link_set,
    input  logic              link_clear,
    output logic              link_ok
);
    import dcache_pkg::*;

    logic  link_valid;
    word_t link_addr;

    // sc may only succeed on the exact linked word
    assign link_ok = link_valid && (link_addr == addr);

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            link_valid <= 1'b0;
        end else if (link_set) begin
            link_valid <= 1'b1;
        end else if (link_clear) begin
            link_valid <= 1'b0;
        end
    end

    // address only matters while valid
    always_ff @(posedge CLK) begin
        if (link_set) begin
            link_addr <= addr;
        end
    end

endmodule

/* hw/dcache_array.sv */
// dcache_array: tag, data, valid, dirty and lru storage with hit compare
`include "dcache_cfg.svh"

module dcache_array (
    input  logic                          CLK,
    input  logic                          nRST,
    input  dcache_pkg::idx_t              req_idx,
    input  dcache_pkg::tag_t              req_tag,
    input  logic                          req_blk,
    output logic                          hit,
    output logic                          hit_way,
    output logic                          victim_way,
    output logic                          victim_dirty,
    output dcache_pkg::tag_t              victim_tag,
    output dcache_pkg::word_t             rd_word0,
    output dcache_pkg::word_t             rd_word1,
    input  logic                          frame_wen,
    input  logic                          wr_way,
    input  logic                          wr_valid,
    input  logic                          wr_dirty,
    input  dcache_pkg::tag_t              wr_tag,
    input  dcache_pkg::word_t             wr_word0,
    input  dcache_pkg::word_t             wr_word1,
    input  logic                          lru_wen,
    input  logic                          lru_val,
    input  logic [`DCACHE_FLUSH_W-1:0]    flush_sel,
    output logic                          flush_dirty,
    output dcache_pkg::tag_t              flush_tag,
    output dcache_pkg::word_t             flush_word0,
    output dcache_pkg::word_t             flush_word1,
    input  logic                          flush_clean
);
    import dcache_pkg::*;

    // status bits, one per frame
    logic [`DCACHE_SETS-1:0][1:0] valid_q;
    logic [`DCACHE_SETS-1:0][1:0] dirty_q;
    // lru bit names the way to evict next
    logic [`DCACHE_SETS-1:0]      lru_q;

    tag_t  tag_q   [`DCACHE_SETS][2];
    word_t word0_q [`DCACHE_SETS][2];
    word_t word1_q [`DCACHE_SETS][2];

    logic hit0, hit1, sel_way, flush_way;
    idx_t flush_idx;

    assign hit0 = valid_q[req_idx][0] && (tag_q[req_idx][0] == req_tag);
    assign hit1 = valid_q[req_idx][1] && (tag_q[req_idx][1] == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit1;

    assign victim_way   = lru_q[req_idx];
    assign victim_dirty = valid_q[req_idx][victim_way] && dirty_q[req_idx][victim_way];
    assign victim_tag   = tag_q[req_idx][victim_way];

    // hit frame when present, otherwise the victim
    // rd_word0 is the requested word, rd_word1 its partner in the block
    assign sel_way  = hit ? hit_way : victim_way;
    assign rd_word0 = req_blk ? word1_q[req_idx][sel_way] : word0_q[req_idx][sel_way];
    assign rd_word1 = req_blk ? word0_q[req_idx][sel_way] : word1_q[req_idx][sel_way];

    // flush view, nothing is dirty past the last frame
    assign flush_idx   = flush_sel[`DCACHE_IDX_W-1:0];
    assign flush_way   = flush_sel[`DCACHE_IDX_W];
    assign flush_dirty = !flush_sel[`DCACHE_FLUSH_W-1]
                       && valid_q[flush_idx][flush_way] && dirty_q[flush_idx][flush_way];
    assign flush_tag   = tag_q[flush_idx][flush_way];
    assign flush_word0 = word0_q[flush_idx][flush_way];
    assign flush_word1 = word1_q[flush_idx][flush_way];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (frame_wen) begin
                valid_q[req_idx][wr_way] <= wr_valid;
                dirty_q[req_idx][wr_way] <= wr_dirty;
            end
            if (flush_clean) begin
                dirty_q[flush_idx][flush_way] <= 1'b0;
            end
            if (lru_wen) begin
                lru_q[req_idx] <= lru_val;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (frame_wen) begin
            tag_q[req_idx][wr_way]   <= wr_tag;
            word0_q[req_idx][wr_way] <= wr_word0;
            word1_q[req_idx][wr_way] <= wr_word1;
        end
    end

    // request writes and flush cleaning use different states
    a_wen_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(frame_wen && flush_clean))
        else $error("frame write and flush clean in the same cycle");

endmodule

/* hw/dcache_pkg.sv */
// word, tag and index types and the controller state enum
`include "dcache_cfg.svh"

package dcache_pkg;

    // one data or address word
    typedef logic [`DCACHE_WORD_W-1:0] word_t;

    // stored tag
    typedef logic [`DCACHE_TAG_W-1:0] tag_t;

    // set index
    typedef logic [`DCACHE_IDX_W-1:0] idx_t;

    // controller states
    typedef enum logic [3:0] {
        IDLE,
        WRITEBACK1,
        WRITEBACK2,
        LOAD1,
        LOAD2,
        STORE_UPDATE,
        CHECK_DIRTY,
        FLUSH_WB1,
        FLUSH_WB2,
        HALTED
    } dcache_state_t;

endpackage

/* hw/dcache_cfg.svh */
// cache geometry and field width macros
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// word and address width
`define DCACHE_WORD_W 32

// 8 sets, two words per block, byte addressed
`define DCACHE_IDX_W 3
`define DCACHE_BLK_W 1
`define DCACHE_BYTE_W 2
`define DCACHE_SETS (1 << `DCACHE_IDX_W)

// whatever is left of the address after index and offsets
`define DCACHE_TAG_W (`DCACHE_WORD_W - `DCACHE_IDX_W - `DCACHE_BLK_W - `DCACHE_BYTE_W)

// flush counter: index, way, plus one bit to step past the last frame
`define DCACHE_FLUSH_W (`DCACHE_IDX_W + 2)

`endif
